// File: include/adapter_settings.svh
// ##############################
// L1.5 adapter settings
// Widths and depths shared by the
// packages and the top level
// ##############################

`ifndef ADAPTER_SETTINGS_SVH
`define ADAPTER_SETTINGS_SVH

`define ADAPTER_ADDR_WIDTH 40   // Physical address
`define ADAPTER_DATA_WIDTH 64   // One double-word per beat
`define ADAPTER_ID_WIDTH 4      // Cache-side request id
`define ADAPTER_PID_WIDTH 3     // Requester port id

// One bit gives two outstanding requests
`define ADAPTER_TID_WIDTH 1
`define ADAPTER_INVAL_DEPTH 4   // Dcache invalidation queue

`endif

// File: src/mem_pkg.sv
// ##############################
// Cache-side memory types
// Request kinds, ids and the
// invalidation queue entry
// ##############################
`default_nettype none
`include "adapter_settings.svh"

package mem_pkg;

    typedef enum logic [2:0] {
        IFILL,
        READ,
        WRITE,
        UNC_READ,
        UNC_WRITE
    } req_kind_t;

    typedef logic [`ADAPTER_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`ADAPTER_DATA_WIDTH-1:0] mem_data_t;
    typedef logic [`ADAPTER_DATA_WIDTH/8-1:0] mem_be_t;
    typedef logic [`ADAPTER_ID_WIDTH-1:0] mem_id_t;
    typedef logic [`ADAPTER_PID_WIDTH-1:0] mem_pid_t;

    typedef struct packed {
        mem_addr_t line_addr;   // 16-byte aligned
    } inval_entry_t;

    // L1.5 is big-endian, the cache side little-endian
    function automatic mem_data_t swap_bytes(input mem_data_t d);
        mem_data_t s;
        for (int i = 0; i < $bits(mem_data_t) / 8; i++) begin
            s[i*8 +: 8] = d[($bits(mem_data_t) / 8 - 1 - i)*8 +: 8];
        end
        return s;
    endfunction

endpackage

`default_nettype wire

// File: src/l15_pkg.sv
// ##############################
// L1.5 interface types
// OpenPiton request and return
// encodings, size and thread id
// ##############################
`default_nettype none
`include "adapter_settings.svh"

package l15_pkg;

    typedef enum logic [4:0] {
        LOAD  = 5'b00000,
        STORE = 5'b00001,
        IMISS = 5'b10000
    } l15_rqtype_t;

    typedef enum logic [3:0] {
        LOAD_RET  = 4'b0000,
        IFILL_RET = 4'b0001,
        EVICT_REQ = 4'b0011,   // Invalidation only, no requester
        ST_ACK    = 4'b0100,
        ERR_RET   = 4'b1100
    } l15_rettype_t;

    // 0..3 give 1..8 bytes, 7 a whole line
    typedef logic [2:0] l15_size_t;

    typedef logic [`ADAPTER_TID_WIDTH-1:0] l15_tid_t;

    localparam int unsigned NUM_TIDS = 2 ** `ADAPTER_TID_WIDTH;

endpackage

`default_nettype wire

// File: src/tid_table_if.sv
// ##############################
// Thread table interface
// Write from request control,
// read by the return thread id
// ##############################
`timescale 1ns/1ps
`default_nettype none

interface tid_table_if import mem_pkg::*; import l15_pkg::*; ();

    logic     wr_en;
    l15_tid_t wr_tid;
    mem_id_t  wr_id;
    mem_pid_t wr_pid;
    l15_tid_t rd_tid;   // From the return decoder
    mem_id_t  rd_id;
    mem_pid_t rd_pid;

    modport ctrl (output wr_en, wr_tid, wr_id, wr_pid);
    modport tbl (input wr_en, wr_tid, wr_id, wr_pid, rd_tid, output rd_id, rd_pid);

endinterface

`default_nettype wire

// File: src/fifo_reg.sv
// ##############################
// Register FIFO
// Circular buffer, optionally
// prefilled with its own indices
// ##############################
`timescale 1ns/1ps
`default_nettype none

module fifo_reg #(
    parameter int unsigned DEPTH = 2,
    parameter bit PREFILL = 1'b0,
    parameter type fifo_data_t = logic
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       push_i,
    input  fifo_data_t data_i,
    output logic       full_o,
    input  logic       pop_i,
    output fifo_data_t data_o,
    output logic       valid_o
);
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam int unsigned DATA_W = $bits(fifo_data_t);

    fifo_data_t mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;   // Wrapped already when prefilled
            rd_ptr_q <= '0;
            count_q  <= PREFILL ? CNT_W'(DEPTH) : '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    if (PREFILL) begin : g_prefill
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem_q[i] <= fifo_data_t'(DATA_W'(i));   // Entry i holds i
                end
            end else if (do_push) begin
                mem_q[wr_ptr_q] <= data_i;
            end
        end
    end else begin : g_plain
        always_ff @(posedge clk_i) begin
            if (do_push) begin
                mem_q[wr_ptr_q] <= data_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/req_ctrl.sv
// ##############################
// Request control
// L1.5 request FSM with a pool
// of free thread ids
// ##############################
`timescale 1ns/1ps
`default_nettype none

module req_ctrl import mem_pkg::*; import l15_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    input  mem_id_t  req_id_i,
    input  mem_pid_t req_pid_i,
    output logic     req_ready_o,
    output logic     l15_val_o,
    output l15_tid_t l15_threadid_o,
    input  logic     l15_header_ack_i,
    input  logic     l15_ack_i,
    input  logic     tid_release_i,
    input  l15_tid_t tid_release_id_i,
    tid_table_if.ctrl tbl
);
    typedef enum logic [1:0] {
        IDLE,
        WAIT_HEADER_ACK,
        WAIT_ACK
    } state_t;

    state_t   state_q;
    state_t   state_d;
    logic     pool_valid;
    l15_tid_t pool_head;
    logic     done;

    // Never overflows, only ids handed out come back
    fifo_reg #(
        .DEPTH       (NUM_TIDS),
        .PREFILL     (1'b1),
        .fifo_data_t (l15_tid_t)
    ) u_tid_pool (
        .clk_i,
        .rst_ni,
        .push_i  (tid_release_i),
        .data_i  (tid_release_id_i),
        .full_o  (),
        .pop_i   (done),
        .data_o  (pool_head),
        .valid_o (pool_valid)
    );

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        done      = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && pool_valid) begin
                    l15_val_o = 1'b1;
                    if (!l15_header_ack_i) begin
                        state_d = WAIT_HEADER_ACK;
                    end else if (l15_ack_i) begin
                        done = 1'b1;   // Both acks at once
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_HEADER_ACK: begin
                l15_val_o = 1'b1;
                if (l15_header_ack_i) begin
                    done    = l15_ack_i;
                    state_d = l15_ack_i ? IDLE : WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                // Valid is down but fields still held by the cache
                if (l15_ack_i) begin
                    done    = 1'b1;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_ready_o    = done;
    assign l15_threadid_o = pool_head;

    assign tbl.wr_en  = done;   // Requester info stored against the id
    assign tbl.wr_tid = pool_head;
    assign tbl.wr_id  = req_id_i;
    assign tbl.wr_pid = req_pid_i;

endmodule

`default_nettype wire

// File: src/req_encode.sv
// ##############################
// Request encoder
// Maps cache requests to L1.5
// type, size, address and data
// ##############################
`timescale 1ns/1ps
`default_nettype none

module req_encode import mem_pkg::*; import l15_pkg::*; (
    input  req_kind_t   req_kind_i,
    input  logic        req_cacheable_i,
    input  mem_addr_t   req_addr_i,
    input  l15_size_t   req_size_i,
    input  mem_data_t   req_wdata_i,
    input  mem_be_t     req_be_i,
    output l15_rqtype_t l15_rqtype_o,
    output logic        l15_nc_o,
    output l15_size_t   l15_size_o,
    output mem_addr_t   l15_address_o,
    output mem_data_t   l15_data_o
);
    l15_size_t st_size;
    logic [2:0] st_offset;
    mem_data_t lane_data;
    mem_data_t st_data;

    // Store size and lowest enabled byte
    always_comb begin
        st_offset = '0;
        for (int i = $bits(mem_be_t) - 1; i >= 0; i--) begin
            if (req_be_i[i]) begin
                st_offset = 3'(i);
            end
        end
        case ($countones(req_be_i))
            1: st_size = 3'd0;
            2: st_size = 3'd1;
            4: st_size = 3'd2;
            default: st_size = 3'd3;
        endcase
        if (st_size == 3'd3) begin
            st_offset = '0;   // Odd masks go out as a full double-word
        end
    end

    assign lane_data = req_wdata_i >> {st_offset, 3'b000};

    // Uncached stores replicate the enabled bytes
    always_comb begin
        case (st_size[1:0])
            2'd0: st_data = {8{lane_data[7:0]}};
            2'd1: st_data = {4{lane_data[15:0]}};
            2'd2: st_data = {2{lane_data[31:0]}};
            default: st_data = req_wdata_i;
        endcase
        if (req_kind_i != UNC_WRITE) begin
            st_data = req_wdata_i;
        end
    end

    always_comb begin
        l15_address_o = req_addr_i;
        case (req_kind_i)
            IFILL: begin
                l15_rqtype_o = IMISS;
                l15_size_o   = req_cacheable_i ? 3'd7 : 3'd2;   // Line or 4 bytes
            end
            WRITE, UNC_WRITE: begin
                l15_rqtype_o  = STORE;
                l15_size_o    = st_size;
                l15_address_o = {req_addr_i[$bits(mem_addr_t)-1:3], st_offset};
            end
            default: begin
                l15_rqtype_o = LOAD;
                l15_size_o   = req_size_i;
            end
        endcase
    end

    assign l15_nc_o   = !req_cacheable_i;
    assign l15_data_o = swap_bytes(st_data);

endmodule

`default_nettype wire

// File: src/resp_decode.sv
// ##############################
// Return decoder
// Acknowledge, routing, data swap
// and dcache invalidations
// ##############################
`timescale 1ns/1ps
`default_nettype none

module resp_decode import mem_pkg::*; import l15_pkg::*; (
    input  logic         l15_rtrn_val_i,
    input  l15_rettype_t l15_returntype_i,
    input  l15_tid_t     l15_rtrn_threadid_i,
    input  mem_data_t    l15_rtrn_data_i,
    input  logic         l15_inval_dcache_i,
    input  mem_addr_t    l15_inval_address_i,
    output logic         l15_req_ack_o,
    input  logic         resp_ready_i,
    output logic         resp_valid_o,
    output logic         resp_error_o,
    output mem_data_t    resp_data_o,
    output logic         tid_release_o,
    output logic         inval_push_o,
    input  logic         inval_full_i,
    output inval_entry_t inval_entry_o,
    output l15_tid_t     rd_tid_o
);
    logic is_evict;
    logic inval_room;

    assign is_evict   = (l15_returntype_i == EVICT_REQ);
    assign inval_room = !l15_inval_dcache_i || !inval_full_i;

    // Evictions need no requester, only queue room
    assign l15_req_ack_o = l15_rtrn_val_i && inval_room && (is_evict || resp_ready_i);
    assign resp_valid_o  = l15_rtrn_val_i && inval_room && !is_evict;

    assign resp_error_o = (l15_returntype_i == ERR_RET);
    assign resp_data_o  = swap_bytes(l15_rtrn_data_i);
    assign rd_tid_o     = l15_rtrn_threadid_i;   // Table lookup of the requester

    assign tid_release_o = resp_valid_o && resp_ready_i;

    assign inval_push_o = l15_req_ack_o && l15_inval_dcache_i;
    assign inval_entry_o.line_addr = {l15_inval_address_i[$bits(mem_addr_t)-1:4], 4'b0000};

endmodule

`default_nettype wire

// File: src/thread_table.sv
// ##############################
// Thread table
// Request id and port id per
// L1.5 thread id
// ##############################
`timescale 1ns/1ps
`default_nettype none

module thread_table import mem_pkg::*; import l15_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    tid_table_if.tbl tbl
);
    mem_id_t  id_q  [NUM_TIDS];
    mem_pid_t pid_q [NUM_TIDS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_TIDS; i++) begin
                id_q[i]  <= '0;
                pid_q[i] <= '0;
            end
        end else if (tbl.wr_en) begin
            id_q[tbl.wr_tid]  <= tbl.wr_id;
            pid_q[tbl.wr_tid] <= tbl.wr_pid;
        end
    end

    // Same-cycle lookup for the return path
    assign tbl.rd_id  = id_q[tbl.rd_tid];
    assign tbl.rd_pid = pid_q[tbl.rd_tid];

endmodule

`default_nettype wire

// File: src/l15_adapter.sv
// ##############################
// Cache to L1.5 adapter
// Encodes cache requests for the
// L1.5, routes returns by thread
// id, queues invalidations
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "adapter_settings.svh"

module l15_adapter import mem_pkg::*; import l15_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         req_valid_i,
    input  req_kind_t    req_kind_i,
    input  logic         req_cacheable_i,
    input  mem_id_t      req_id_i,
    input  mem_pid_t     req_pid_i,
    input  mem_addr_t    req_addr_i,
    input  l15_size_t    req_size_i,
    input  mem_data_t    req_wdata_i,
    input  mem_be_t      req_be_i,
    output logic         req_ready_o,
    output logic         l15_val_o,
    output l15_rqtype_t  l15_rqtype_o,
    output logic         l15_nc_o,
    output l15_size_t    l15_size_o,
    output l15_tid_t     l15_threadid_o,
    output mem_addr_t    l15_address_o,
    output mem_data_t    l15_data_o,
    input  logic         l15_header_ack_i,
    input  logic         l15_ack_i,
    input  logic         l15_rtrn_val_i,
    input  l15_rettype_t l15_returntype_i,
    input  l15_tid_t     l15_rtrn_threadid_i,
    input  mem_data_t    l15_rtrn_data_i,
    input  logic         l15_inval_dcache_i,
    input  mem_addr_t    l15_inval_address_i,
    output logic         l15_req_ack_o,
    input  logic         resp_ready_i,
    output logic         resp_valid_o,
    output logic         resp_error_o,
    output mem_id_t      resp_id_o,
    output mem_pid_t     resp_pid_o,
    output mem_data_t    resp_data_o,
    input  logic         inval_ready_i,
    output logic         inval_valid_o,
    output mem_addr_t    inval_addr_o
);
    logic         tid_release;
    logic         inval_push;
    logic         inval_full;
    inval_entry_t inval_entry;
    inval_entry_t inval_head;

    tid_table_if tbl ();

    req_ctrl u_req_ctrl (
        .tid_release_i    (tid_release),
        .tid_release_id_i (l15_rtrn_threadid_i),
        .*
    );

    req_encode u_req_encode (.*);

    resp_decode u_resp_decode (
        .tid_release_o (tid_release),
        .inval_push_o  (inval_push),
        .inval_full_i  (inval_full),
        .inval_entry_o (inval_entry),
        .rd_tid_o      (tbl.rd_tid),
        .*
    );

    thread_table u_thread_table (.*);

    fifo_reg #(
        .DEPTH       (`ADAPTER_INVAL_DEPTH),
        .PREFILL     (1'b0),
        .fifo_data_t (inval_entry_t)
    ) u_inval_fifo (
        .clk_i,
        .rst_ni,
        .push_i  (inval_push),
        .data_i  (inval_entry),
        .full_o  (inval_full),
        .pop_i   (inval_ready_i),
        .data_o  (inval_head),
        .valid_o (inval_valid_o)
    );

    assign resp_id_o    = tbl.rd_id;
    assign resp_pid_o   = tbl.rd_pid;
    assign inval_addr_o = inval_head.line_addr;

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// ##############################
// Testbench clock and reset
// Free-running clock, reset held
// low for a number of cycles
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 100,
    parameter int unsigned RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;   // Released away from the active edge
    end

endmodule

`default_nettype wire

// File: testbench/tb_l15_adapter.sv
// ##############################
// L1.5 adapter testbench
// Drives cache requests, models
// the L1.5 and checks encoding,
// routing and invalidations
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "adapter_settings.svh"

module tb_l15_adapter import mem_pkg::*; import l15_pkg::*; ();
    localparam int unsigned PERIOD_NS  = 100;
    localparam int unsigned WAIT_LIMIT = 50;
    localparam int unsigned MARGIN     = 2;
    localparam int unsigned TEST_CYCLES [5] = '{60, 120, 80, 140, 120};

    logic clk_i, rst_ni;
    logic req_valid_i, req_cacheable_i, req_ready_o;
    req_kind_t req_kind_i;
    mem_id_t req_id_i, resp_id_o;
    mem_pid_t req_pid_i, resp_pid_o;
    mem_addr_t req_addr_i, l15_address_o, l15_inval_address_i, inval_addr_o;
    l15_size_t req_size_i, l15_size_o;
    mem_data_t req_wdata_i, l15_data_o, l15_rtrn_data_i, resp_data_o;
    mem_be_t req_be_i;
    logic l15_val_o, l15_nc_o, l15_header_ack_i, l15_ack_i;
    l15_rqtype_t l15_rqtype_o;
    l15_tid_t l15_threadid_o, l15_rtrn_threadid_i;
    logic l15_rtrn_val_i, l15_inval_dcache_i, l15_req_ack_o;
    l15_rettype_t l15_returntype_i;
    logic resp_ready_i, resp_valid_o, resp_error_o;
    logic inval_ready_i, inval_valid_o;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests = 0;
    mem_id_t exp_id [NUM_TIDS];
    mem_pid_t exp_pid [NUM_TIDS];

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) u_clk_gen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    l15_adapter UUT (.*);

    // Ready to the cache only in the ack cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) req_ready_o |-> l15_ack_i)
        else begin
            $display("error at %0t: req_ready_o raised without l15_ack_i", $time);
            errors++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o |-> (l15_returntype_i != EVICT_REQ))
        else begin
            $display("error at %0t: resp_valid_o raised for an eviction", $time);
            errors++;
        end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic report_test(input string name, input int unsigned errors_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // Expected L1.5 fields from the encoding rules
    task automatic expected_encoding(input req_kind_t kind, input logic cacheable,
            input mem_addr_t addr, input l15_size_t size, input mem_data_t wdata,
            input mem_be_t be, output l15_rqtype_t e_type, output l15_size_t e_size,
            output mem_addr_t e_addr, output mem_data_t e_data);
        int unsigned n;
        int unsigned low;
        int unsigned chunk;
        mem_data_t lanes;
        n = $countones(be);
        low = 0;
        for (int b = 7; b >= 0; b--) begin
            if (be[b]) low = b;
        end
        e_type = LOAD;
        e_size = size;
        e_addr = addr;
        lanes = wdata;
        if (kind == IFILL) begin
            e_type = IMISS;
            e_size = cacheable ? 3'd7 : 3'd2;
        end else if (kind == WRITE || kind == UNC_WRITE) begin
            e_type = STORE;
            case (n)
                1: e_size = 3'd0;
                2: e_size = 3'd1;
                4: e_size = 3'd2;
                default: e_size = 3'd3;
            endcase
            if (e_size == 3'd3) low = 0;
            e_addr = {addr[`ADAPTER_ADDR_WIDTH-1:3], 3'(low)};
            if (kind == UNC_WRITE && e_size != 3'd3) begin
                chunk = 1 << e_size;
                for (int b = 0; b < 8; b++) begin
                    lanes[b*8 +: 8] = wdata[(low + b % chunk)*8 +: 8];
                end
            end
        end
        e_data = {<<8{lanes}};   // Big-endian on the L1.5 side
    endtask

    // One request through the L1.5 model, returns the thread id used
    task automatic run_request(input req_kind_t kind, input logic cacheable,
            input mem_addr_t addr, input l15_size_t size, input mem_data_t wdata,
            input mem_be_t be, input int unsigned hdr_delay, input int unsigned ack_delay,
            output l15_tid_t tid);
        l15_rqtype_t e_type;
        l15_size_t e_size;
        mem_addr_t e_addr;
        mem_data_t e_data;
        int unsigned wait_cnt;
        expected_encoding(kind, cacheable, addr, size, wdata, be, e_type, e_size, e_addr, e_data);
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_kind_i = kind;
        req_cacheable_i = cacheable;
        req_addr_i = addr;
        req_size_i = size;
        req_wdata_i = wdata;
        req_be_i = be;
        req_id_i = mem_id_t'($urandom);
        req_pid_i = mem_pid_t'($urandom);
        #1;
        wait_cnt = 0;
        while (!l15_val_o && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk_i);
            #1;
            wait_cnt++;
        end
        if (!l15_val_o) report_fault("l15_val_o never rose for a request");
        check("l15_rqtype_o", 64'(l15_rqtype_o), 64'(e_type));
        check("l15_nc_o", 64'(l15_nc_o), 64'(!cacheable));
        check("l15_size_o", 64'(l15_size_o), 64'(e_size));
        check("l15_address_o", 64'(l15_address_o), 64'(e_addr));
        if (e_type == STORE) check("l15_data_o", l15_data_o, e_data);
        repeat (hdr_delay) begin
            @(negedge clk_i);
            #1;
            check("l15_val_o", 64'(l15_val_o), 64'd1);
            check("req_ready_o", 64'(req_ready_o), 64'd0);
        end
        @(negedge clk_i);
        l15_header_ack_i = 1'b1;
        l15_ack_i = (ack_delay == 0);
        #1;
        tid = l15_threadid_o;
        exp_id[tid] = req_id_i;
        exp_pid[tid] = req_pid_i;
        check("req_ready_o", 64'(req_ready_o), 64'(ack_delay == 0));
        if (ack_delay > 0) begin
            @(negedge clk_i);
            l15_header_ack_i = 1'b0;
            #1;
            check("l15_val_o", 64'(l15_val_o), 64'd0);
            repeat (ack_delay - 1) begin
                check("req_ready_o", 64'(req_ready_o), 64'd0);
                @(negedge clk_i);
                #1;
            end
            @(negedge clk_i);
            l15_ack_i = 1'b1;
            #1;
            check("req_ready_o", 64'(req_ready_o), 64'd1);
        end
        @(negedge clk_i);
        l15_header_ack_i = 1'b0;
        l15_ack_i = 1'b0;
        req_valid_i = 1'b0;
    endtask

    task automatic send_return(input l15_rettype_t rtype, input l15_tid_t tid,
            input logic inval, input mem_addr_t iaddr);
        mem_data_t data;
        mem_data_t exp_data;
        int unsigned wait_cnt;
        data = {$urandom, $urandom};
        exp_data = {<<8{data}};
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b1;
        l15_returntype_i = rtype;
        l15_rtrn_threadid_i = tid;
        l15_rtrn_data_i = data;
        l15_inval_dcache_i = inval;
        l15_inval_address_i = iaddr;
        resp_ready_i = 1'b1;
        #1;
        wait_cnt = 0;
        while (!l15_req_ack_o && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk_i);
            #1;
            wait_cnt++;
        end
        if (!l15_req_ack_o) report_fault("return packet was never acknowledged");
        if (rtype == EVICT_REQ) begin
            check("resp_valid_o", 64'(resp_valid_o), 64'd0);
        end else begin
            check("resp_valid_o", 64'(resp_valid_o), 64'd1);
            check("resp_id_o", 64'(resp_id_o), 64'(exp_id[tid]));
            check("resp_pid_o", 64'(resp_pid_o), 64'(exp_pid[tid]));
            check("resp_data_o", resp_data_o, exp_data);
            check("resp_error_o", 64'(resp_error_o), 64'(rtype == ERR_RET));
        end
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b0;
        l15_inval_dcache_i = 1'b0;
    endtask

    initial begin
        int unsigned total;
        total = 8;
        foreach (TEST_CYCLES[i]) total += TEST_CYCLES[i];
        #(total * PERIOD_NS * MARGIN);
        $display("error at %0t: watchdog expired, the run did not finish", $time);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int unsigned start;
        int unsigned wait_cnt;
        l15_tid_t t0, t1, t2;
        mem_addr_t ev_addr;
        void'($urandom(6));
        req_valid_i = 1'b0;
        req_kind_i = READ;
        req_cacheable_i = 1'b0;
        req_id_i = '0;
        req_pid_i = '0;
        req_addr_i = '0;
        req_size_i = '0;
        req_wdata_i = '0;
        req_be_i = '0;
        l15_header_ack_i = 1'b0;
        l15_ack_i = 1'b0;
        l15_rtrn_val_i = 1'b0;
        l15_returntype_i = LOAD_RET;
        l15_rtrn_threadid_i = '0;
        l15_rtrn_data_i = '0;
        l15_inval_dcache_i = 1'b0;
        l15_inval_address_i = '0;
        resp_ready_i = 1'b1;
        inval_ready_i = 1'b0;
        @(posedge rst_ni);

        start = errors;
        run_request(READ, 1'b1, 40'h12_3456_7898, 3'd3, '0, '0,
            $urandom_range(3), $urandom_range(3), t0);
        send_return(LOAD_RET, t0, 1'b0, '0);
        report_test("cached load", start);

        start = errors;
        run_request(UNC_WRITE, 1'b0, 40'h00_0000_1000, '0, {$urandom, $urandom}, 8'h20, 1, 0, t0);
        send_return(ST_ACK, t0, 1'b0, '0);
        run_request(UNC_WRITE, 1'b0, 40'h00_0000_2008, '0, {$urandom, $urandom}, 8'h0c, 0, 2, t0);
        send_return(ST_ACK, t0, 1'b0, '0);
        run_request(UNC_WRITE, 1'b0, 40'h00_0000_3010, '0, {$urandom, $urandom}, 8'hf0, 2, 1, t0);
        send_return(ST_ACK, t0, 1'b0, '0);
        report_test("uncached store", start);

        start = errors;
        run_request(IFILL, 1'b1, 40'h00_8000_0040, '0, '0, '0, 3, 2, t0);
        send_return(IFILL_RET, t0, 1'b0, '0);
        run_request(IFILL, 1'b0, 40'h00_8000_0044, '0, '0, '0, 4, 0, t0);
        send_return(ERR_RET, t0, 1'b0, '0);
        report_test("instruction fill", start);

        start = errors;
        run_request(READ, 1'b1, 40'h00_0000_0100, 3'd3, '0, '0, 0, 1, t0);
        run_request(READ, 1'b1, 40'h00_0000_0200, 3'd2, '0, '0, 1, 0, t1);
        check("l15_threadid_o distinct", 64'(t0 != t1), 64'd1);
        @(negedge clk_i);
        req_kind_i = READ;   // Third request, held until its ready
        req_cacheable_i = 1'b0;
        req_addr_i = 40'h00_0000_0300;
        req_size_i = 3'd1;
        req_id_i = mem_id_t'($urandom);
        req_pid_i = mem_pid_t'($urandom);
        req_valid_i = 1'b1;
        repeat (4) begin
            #1;
            check("l15_val_o", 64'(l15_val_o), 64'd0);
            @(negedge clk_i);
        end
        l15_rtrn_val_i = 1'b1;
        l15_returntype_i = LOAD_RET;
        l15_rtrn_threadid_i = t0;
        resp_ready_i = 1'b0;
        repeat (3) begin
            #1;
            check("l15_req_ack_o", 64'(l15_req_ack_o), 64'd0);
            check("resp_valid_o", 64'(resp_valid_o), 64'd1);
            check("l15_val_o", 64'(l15_val_o), 64'd0);
            @(negedge clk_i);
        end
        resp_ready_i = 1'b1;
        #1;
        check("l15_req_ack_o", 64'(l15_req_ack_o), 64'd1);
        check("resp_id_o", 64'(resp_id_o), 64'(exp_id[t0]));
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b0;
        #1;
        check("l15_val_o", 64'(l15_val_o), 64'd1);   // Released id usable now
        @(negedge clk_i);
        l15_header_ack_i = 1'b1;
        l15_ack_i = 1'b1;
        #1;
        t2 = l15_threadid_o;
        exp_id[t2] = req_id_i;
        exp_pid[t2] = req_pid_i;
        check("req_ready_o", 64'(req_ready_o), 64'd1);
        check("l15_threadid_o reused", 64'(t2), 64'(t0));
        @(negedge clk_i);
        l15_header_ack_i = 1'b0;
        l15_ack_i = 1'b0;
        req_valid_i = 1'b0;
        send_return(LOAD_RET, t1, 1'b0, '0);
        send_return(LOAD_RET, t2, 1'b0, '0);
        report_test("thread id exhaustion", start);

        start = errors;
        #1;
        check("inval_valid_o", 64'(inval_valid_o), 64'd0);
        ev_addr = 40'h00_abcd_ef57;
        send_return(EVICT_REQ, 1'b0, 1'b1, ev_addr);
        #1;
        check("inval_valid_o", 64'(inval_valid_o), 64'd1);
        check("inval_addr_o", 64'(inval_addr_o),
            64'({ev_addr[`ADAPTER_ADDR_WIDTH-1:4], 4'h0}));
        repeat (3) send_return(EVICT_REQ, 1'b1, 1'b1, 40'h00_0000_1234);
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b1;
        l15_returntype_i = EVICT_REQ;
        l15_inval_dcache_i = 1'b1;
        repeat (3) begin
            #1;
            check("l15_req_ack_o", 64'(l15_req_ack_o), 64'd0);
            @(negedge clk_i);
        end
        inval_ready_i = 1'b1;
        #1;
        wait_cnt = 0;
        while (!l15_req_ack_o && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk_i);
            #1;
            wait_cnt++;
        end
        if (!l15_req_ack_o) report_fault("eviction stayed stalled after the queue drained");
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b0;
        l15_inval_dcache_i = 1'b0;
        repeat (8) @(negedge clk_i);
        #1;
        check("inval_valid_o", 64'(inval_valid_o), 64'd0);
        report_test("eviction and invalidation", start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
src/mem_pkg.sv
src/l15_pkg.sv
src/tid_table_if.sv
src/fifo_reg.sv
src/req_ctrl.sv
src/req_encode.sv
src/resp_decode.sv
src/thread_table.sv
src/l15_adapter.sv
testbench/tb_clock_gen.sv
testbench/tb_l15_adapter.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l15_adapter
RTL_TOP   ?= l15_adapter
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
